// ==== design/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Register width.
`define XLEN 64

// Address width.
`define ALEN 64

// Instruction width.
`define ILEN 32

`endif

// ==== design/decode_pkg.sv ====
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    // Major opcodes, instruction bits 6:2.
    typedef enum logic [4:0] {
        OP_LOAD      = 5'b00_000,
        OP_MISC_MEM  = 5'b00_011,
        OP_OP_IMM    = 5'b00_100,
        OP_AUIPC     = 5'b00_101,
        OP_OP_IMM_32 = 5'b00_110,
        OP_STORE     = 5'b01_000,
        OP_OP        = 5'b01_100,
        OP_LUI       = 5'b01_101,
        OP_OP_32     = 5'b01_110,
        OP_BRANCH    = 5'b11_000,
        OP_JALR      = 5'b11_001,
        OP_JAL       = 5'b11_011,
        OP_SYSTEM    = 5'b11_100
    } opcode_t;

    localparam logic [3:0] CAUSE_ILLEGAL = 4'd2;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One word, every format view.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic             exception;
        logic [3:0]       trap_cause;
        logic [`ILEN-1:0] instruction;
        logic [`ALEN-1:0] addr;
        logic [`ALEN-1:0] next_addr;
    } fetch_t;

    typedef struct packed {
        logic             exception;
        logic [3:0]       trap_cause;
        logic [`ILEN-1:0] instruction;
        logic [`ALEN-1:0] addr;
        logic [`ALEN-1:0] next_addr;
        logic [`ILEN-1:0] expanded;
    } expanded_t;

    // Register zero means no forward.
    typedef struct packed {
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } bypass_t;

    typedef struct packed {
        logic             exception;
        logic [3:0]       trap_cause;
        logic             is_jump;
        logic             is_reg_write;
        logic [`ILEN-1:0] original_instruction;
        logic [`ALEN-1:0] addr;
        logic [`ALEN-1:0] next_addr;
        logic [4:0]       opcode;
        logic [4:0]       rd;
        logic [2:0]       funct3;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [6:0]       funct7;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [11:0]      i_imm;
        logic [11:0]      s_imm;
        logic [11:0]      b_imm;
        logic [19:0]      u_imm;
        logic [19:0]      j_imm;
    } decoded_t;

endpackage

`default_nettype wire

// ==== design/decode_control.sv ====
`default_nettype none

module decode_control (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic prev_stalled,
    input  logic next_stalled,
    output logic load_s1,
    output logic load_s2,
    output logic stall_prev,
    output logic stall_next
);

    logic valid_s1;
    logic valid_s2;
    logic drain_s2;

    assign drain_s2   = valid_s2 && !next_stalled;
    assign stall_next = !valid_s2;

    // Stage 2 takes when empty or emptying this cycle.
    assign load_s2    = valid_s1 && (!valid_s2 || drain_s2);

    // Stage 1 is stuck only if full and not moving on.
    assign stall_prev = valid_s1 && !load_s2;
    assign load_s1    = !prev_stalled && !stall_prev && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else if (flush) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            if (load_s1) begin
                valid_s1 <= 1'b1;
            end else if (load_s2) begin
                valid_s1 <= 1'b0;
            end

            if (load_s2) begin
                valid_s2 <= 1'b1;
            end else if (drain_s2) begin
                valid_s2 <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_decompress.sv ====
`default_nettype none

`include "decode_config.svh"

module decode_decompress
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  fetch_t    fetch,
    output expanded_t s1
);

    logic [15:0]      c;
    logic [4:0]       rd_full;
    logic [4:0]       rs2_full;
    logic [4:0]       rp_lo;
    logic [4:0]       rp_hi;
    logic [11:0]      ci_imm;
    logic [11:0]      mem_off;
    logic [12:0]      br_off;
    logic [20:0]      j_off;
    logic [`ILEN-1:0] expanded;
    logic             illegal;
    expanded_t        s1_next;

    assign c        = fetch.instruction[15:0];
    assign rd_full  = c[11:7];
    assign rs2_full = c[6:2];

    // Compressed registers cover x8 to x15.
    assign rp_lo    = {2'b01, c[4:2]};
    assign rp_hi    = {2'b01, c[9:7]};

    assign ci_imm   = {{6{c[12]}}, c[12], c[6:2]};

    // Word offset shared by C.LW and C.SW.
    assign mem_off  = {5'b0, c[5], c[12:10], c[6], 2'b00};

    assign br_off   = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

    assign j_off    = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                       c[5:3], 1'b0};

    always_comb begin
        illegal  = 1'b0;
        expanded = fetch.instruction;
        if (c[1:0] != 2'b11) begin
            case ({c[1:0], c[15:13]})
                // C.LW
                5'b00_010: expanded = {mem_off, rp_hi, 3'b010, rp_lo, 7'b0000011};
                // C.SW
                5'b00_110: expanded = {mem_off[11:5], rp_lo, rp_hi, 3'b010, mem_off[4:0],
                                       7'b0100011};
                // C.ADDI
                5'b01_000: expanded = {ci_imm, rd_full, 3'b000, rd_full, 7'b0010011};
                // C.LI
                5'b01_010: expanded = {ci_imm, 5'd0, 3'b000, rd_full, 7'b0010011};
                // C.J
                5'b01_101: expanded = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                                       5'd0, 7'b1101111};
                // C.BEQZ
                5'b01_110: expanded = {br_off[12], br_off[10:5], 5'd0, rp_hi, 3'b000,
                                       br_off[4:1], br_off[11], 7'b1100011};
                // C.BNEZ
                5'b01_111: expanded = {br_off[12], br_off[10:5], 5'd0, rp_hi, 3'b001,
                                       br_off[4:1], br_off[11], 7'b1100011};
                5'b10_100: begin
                    if (!c[12] && rd_full != 5'd0 && rs2_full == 5'd0) begin
                        // C.JR
                        expanded = {12'd0, rd_full, 3'b000, 5'd0, 7'b1100111};
                    end else if (!c[12] && rd_full != 5'd0) begin
                        // C.MV
                        expanded = {7'd0, rs2_full, 5'd0, 3'b000, rd_full, 7'b0110011};
                    end else if (c[12] && rd_full != 5'd0 && rs2_full != 5'd0) begin
                        // C.ADD
                        expanded = {7'd0, rs2_full, rd_full, 3'b000, rd_full, 7'b0110011};
                    end else begin
                        illegal = 1'b1;
                    end
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    always_comb begin
        s1_next.exception   = fetch.exception || illegal;
        s1_next.trap_cause  = fetch.exception ? fetch.trap_cause :
                              illegal         ? CAUSE_ILLEGAL    : fetch.trap_cause;
        s1_next.instruction = fetch.instruction;
        s1_next.addr        = fetch.addr;
        s1_next.next_addr   = fetch.next_addr;
        s1_next.expanded    = expanded;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1 <= '0;
        end else if (load) begin
            s1 <= s1_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_explode.sv ====
`default_nettype none

`include "decode_config.svh"

module decode_explode
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  expanded_t        s1,
    input  bypass_t          bypass_exec,
    input  bypass_t          bypass_writeback,
    output logic [4:0]       rs1_sel,
    output logic [4:0]       rs2_sel,
    input  logic [`XLEN-1:0] rd1_data,
    input  logic [`XLEN-1:0] rd2_data,
    output decoded_t         decoded
);

    instr_u   ins;
    opcode_t  op;
    logic     known;
    logic     illegal;
    decoded_t s2_next;

    // Exec beats writeback, x0 always reads zero.
    function automatic logic [`XLEN-1:0] operand(input logic [4:0]       sel,
                                                 input logic [`XLEN-1:0] rf_data,
                                                 input bypass_t          ex,
                                                 input bypass_t          wb);
        logic [`XLEN-1:0] value;
        if (sel == 5'd0) begin
            value = '0;
        end else if (ex.rd == sel) begin
            value = ex.data;
        end else if (wb.rd == sel) begin
            value = wb.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign ins     = s1.expanded;
    assign op      = opcode_t'(ins.r.opcode[6:2]);
    assign rs1_sel = ins.r.rs1;
    assign rs2_sel = ins.r.rs2;

    always_comb begin
        case (op)
            OP_LOAD, OP_MISC_MEM, OP_OP_IMM, OP_AUIPC, OP_OP_IMM_32, OP_STORE,
            OP_OP, OP_LUI, OP_OP_32, OP_BRANCH, OP_JALR, OP_JAL, OP_SYSTEM: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign illegal = !known || ins.r.opcode[1:0] != 2'b11;

    always_comb begin
        s2_next.exception            = s1.exception || illegal;
        s2_next.trap_cause           = s1.exception ? s1.trap_cause : CAUSE_ILLEGAL;
        s2_next.is_jump              = op inside {OP_JAL, OP_JALR, OP_BRANCH};
        s2_next.is_reg_write         = ins.r.rd != 5'd0 &&
                                       op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_OP,
                                                  OP_OP_IMM, OP_OP_32, OP_OP_IMM_32, OP_LOAD};
        s2_next.original_instruction = s1.instruction;
        s2_next.addr                 = s1.addr;
        s2_next.next_addr            = s1.next_addr;
        s2_next.opcode               = ins.r.opcode[6:2];
        s2_next.rd                   = ins.r.rd;
        s2_next.funct3               = ins.r.funct3;
        s2_next.rs1                  = ins.r.rs1;
        s2_next.rs2                  = ins.r.rs2;
        s2_next.funct7               = ins.r.funct7;
        s2_next.rs1_data             = operand(ins.r.rs1, rd1_data, bypass_exec,
                                               bypass_writeback);
        s2_next.rs2_data             = operand(ins.r.rs2, rd2_data, bypass_exec,
                                               bypass_writeback);
        s2_next.i_imm                = ins.i.imm;
        s2_next.s_imm                = {ins.s.imm_hi, ins.s.imm_lo};
        s2_next.b_imm                = {ins.b.imm12, ins.b.imm11, ins.b.imm10_5, ins.b.imm4_1};
        s2_next.u_imm                = ins.u.imm;
        s2_next.j_imm                = {ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                                        ins.j.imm10_1};
    end

    // Operand data is held, not refreshed, while stalled.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decoded <= '0;
        end else if (load) begin
            decoded <= s2_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_regfile.sv ====
`default_nettype none

`include "decode_config.svh"

module decode_regfile
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       rs1_sel,
    input  logic [4:0]       rs2_sel,
    output logic [`XLEN-1:0] rd1_data,
    output logic [`XLEN-1:0] rd2_data,
    input  bypass_t          write
);

    // No storage for x0.
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write.rd != 5'd0) begin
            regs[write.rd] <= write.data;
        end
    end

    assign rd1_data = (rs1_sel == 5'd0) ? '0 : regs[rs1_sel];
    assign rd2_data = (rs2_sel == 5'd0) ? '0 : regs[rs2_sel];

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none

`include "decode_config.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  fetch_t   fetch,
    input  logic     prev_stalled,
    input  logic     next_stalled,
    input  bypass_t  bypass_exec,
    input  bypass_t  bypass_writeback,
    output logic     stall_prev,
    output logic     stall_next,
    output decoded_t decoded
);

    logic             load_s1;
    logic             load_s2;
    expanded_t        s1;
    logic [4:0]       rs1_sel;
    logic [4:0]       rs2_sel;
    logic [`XLEN-1:0] rd1_data;
    logic [`XLEN-1:0] rd2_data;

    decode_control i_decode_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .prev_stalled (prev_stalled),
        .next_stalled (next_stalled),
        .load_s1      (load_s1),
        .load_s2      (load_s2),
        .stall_prev   (stall_prev),
        .stall_next   (stall_next)
    );

    decode_decompress i_decode_decompress (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load_s1),
        .fetch (fetch),
        .s1    (s1)
    );

    decode_explode i_decode_explode (
        .clk              (clk),
        .rst_n            (rst_n),
        .load             (load_s2),
        .s1               (s1),
        .bypass_exec      (bypass_exec),
        .bypass_writeback (bypass_writeback),
        .rs1_sel          (rs1_sel),
        .rs2_sel          (rs2_sel),
        .rd1_data         (rd1_data),
        .rd2_data         (rd2_data),
        .decoded          (decoded)
    );

    // The writeback forward doubles as the write port.
    decode_regfile i_decode_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .write    (bypass_writeback)
    );

endmodule

`default_nettype wire

// ==== sim/tb_decode_stage.sv ====
`default_nettype none

`include "decode_config.svh"

module tb_decode_stage
    import decode_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic     clk;
    logic     rst_n;
    logic     flush;
    fetch_t   fetch;
    logic     prev_stalled;
    logic     next_stalled;
    bypass_t  bypass_exec;
    bypass_t  bypass_writeback;
    logic     stall_prev;
    logic     stall_next;
    decoded_t decoded;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng = 32'h69aa_bb6c;

    decode_stage i_decode_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .fetch            (fetch),
        .prev_stalled     (prev_stalled),
        .next_stalled     (next_stalled),
        .bypass_exec      (bypass_exec),
        .bypass_writeback (bypass_writeback),
        .stall_prev       (stall_prev),
        .stall_next       (stall_next),
        .decoded          (decoded)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [4:0] nonzero_reg();
        return 5'(next_rand() % 31 + 1);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] o, input logic [4:0] rs1,
                                          input logic [2:0] f3);
        return {o[12], o[10:5], 5'd0, rs1, f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] o);
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
    endfunction

    task automatic fail_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Slices the equivalent 32-bit word by the RISC-V format rules.
    task automatic check_fields(input decoded_t d, input logic [31:0] w,
                                input logic [31:0] orig, input fetch_t f);
        logic [4:0] op;
        logic       jump;
        logic       wr;
        op   = w[6:2];
        jump = op inside {5'b11000, 5'b11001, 5'b11011};
        wr   = w[11:7] != 5'd0 && op inside {5'b01101, 5'b00101, 5'b11011, 5'b11001,
                                             5'b01100, 5'b00100, 5'b01110, 5'b00110,
                                             5'b00000};
        check_val("original_instruction", 64'(d.original_instruction), 64'(orig));
        check_val("addr", d.addr, f.addr);
        check_val("next_addr", d.next_addr, f.next_addr);
        check_val("exception", 64'(d.exception), 64'd0);
        check_val("opcode", 64'(d.opcode), 64'(op));
        check_val("rd", 64'(d.rd), 64'(w[11:7]));
        check_val("funct3", 64'(d.funct3), 64'(w[14:12]));
        check_val("rs1", 64'(d.rs1), 64'(w[19:15]));
        check_val("rs2", 64'(d.rs2), 64'(w[24:20]));
        check_val("funct7", 64'(d.funct7), 64'(w[31:25]));
        check_val("i_imm", 64'(d.i_imm), 64'(w[31:20]));
        check_val("s_imm", 64'(d.s_imm), 64'({w[31:25], w[11:7]}));
        check_val("b_imm", 64'(d.b_imm), 64'({w[31], w[7], w[30:25], w[11:8]}));
        check_val("u_imm", 64'(d.u_imm), 64'(w[31:12]));
        check_val("j_imm", 64'(d.j_imm), 64'({w[31], w[19:12], w[20], w[30:21]}));
        check_val("is_jump", 64'(d.is_jump), 64'(jump));
        check_val("is_reg_write", 64'(d.is_reg_write), 64'(wr));
    endtask

    function automatic fetch_t make_fetch(input logic [31:0] word);
        fetch_t f;
        f.exception   = 1'b0;
        f.trap_cause  = 4'd0;
        f.instruction = word;
        f.addr        = {32'h0, next_rand() & 32'hffff_fffc};
        f.next_addr   = f.addr + 64'd4;
        return f;
    endfunction

    // Offers one item, then waits until it leaves the stage.
    task automatic push_and_get(input fetch_t f, output decoded_t d);
        int n;
        @(negedge clk);
        fetch        = f;
        prev_stalled = 1'b0;
        next_stalled = 1'b0;
        #1;
        n = 0;
        while (stall_prev) begin
            @(negedge clk);
            #1;
            n++;
            if (n > 50) fail_timeout("stall_prev low");
        end
        @(posedge clk);
        @(negedge clk);
        prev_stalled = 1'b1;
        n = 0;
        while (stall_next) begin
            @(negedge clk);
            n++;
            if (n > 50) fail_timeout("stall_next low");
        end
        d = decoded;
    endtask

    task automatic test_register_read();
        logic [63:0] v5;
        logic [63:0] v6;
        decoded_t    d;
        fetch_t      f;
        v5 = {next_rand(), next_rand()};
        v6 = {next_rand(), next_rand()};
        @(negedge clk);
        bypass_writeback = '{rd: 5'd5, data: v5};
        @(negedge clk);
        bypass_writeback = '{rd: 5'd6, data: v6};
        @(negedge clk);
        bypass_writeback = '0;
        repeat (2) @(negedge clk);
        f = make_fetch(enc_r(7'd0, 5'd6, 5'd5, 3'b000, 5'd3, 7'b0110011));
        push_and_get(f, d);
        check_fields(d, f.instruction, f.instruction, f);
        check_val("rs1_data", d.rs1_data, v5);
        check_val("rs2_data", d.rs2_data, v6);
    endtask

    task automatic test_immediates();
        logic [6:0]  ops [8];
        logic [31:0] w;
        decoded_t    d;
        fetch_t      f;
        ops = '{7'b0000011, 7'b0010011, 7'b1100111, 7'b0100011,
                7'b1100011, 7'b0110111, 7'b0010111, 7'b1101111};
        for (int i = 0; i < 24; i++) begin
            w      = next_rand();
            w[6:0] = ops[i % 8];
            f = make_fetch(w);
            push_and_get(f, d);
            check_fields(d, w, w, f);
        end
    endtask

    task automatic test_compressed();
        logic [15:0] c;
        logic [31:0] w;
        logic [2:0]  rp1;
        logic [2:0]  rp2;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [5:0]  imm;
        logic [6:0]  off;
        logic [11:0] jo;
        logic [8:0]  bo;
        decoded_t    d;
        fetch_t      f;
        for (int k = 0; k < 20; k++) begin
            rp1 = 3'(next_rand());
            rp2 = 3'(next_rand());
            r1  = nonzero_reg();
            r2  = nonzero_reg();
            imm = 6'(next_rand());
            off = {5'(next_rand()), 2'b00};
            jo  = {11'(next_rand()), 1'b0};
            bo  = {8'(next_rand()), 1'b0};
            case (k % 10)
                0: begin
                    c = {3'b010, off[5:3], rp1, off[2], off[6], rp2, 2'b00};
                    w = enc_i({5'd0, off}, {2'b01, rp1}, 3'b010, {2'b01, rp2}, 7'b0000011);
                end
                1: begin
                    c = {3'b110, off[5:3], rp1, off[2], off[6], rp2, 2'b00};
                    w = enc_s({5'd0, off}, {2'b01, rp2}, {2'b01, rp1});
                end
                2: begin
                    c = {3'b000, imm[5], r1, imm[4:0], 2'b01};
                    w = enc_i({{6{imm[5]}}, imm}, r1, 3'b000, r1, 7'b0010011);
                end
                3: begin
                    c = {3'b010, imm[5], r1, imm[4:0], 2'b01};
                    w = enc_i({{6{imm[5]}}, imm}, 5'd0, 3'b000, r1, 7'b0010011);
                end
                4: begin
                    c = {3'b101, jo[11], jo[4], jo[9:8], jo[10], jo[6], jo[7], jo[3:1],
                         jo[5], 2'b01};
                    w = enc_j({{9{jo[11]}}, jo});
                end
                5: begin
                    c = {4'b1000, r1, 5'd0, 2'b10};
                    w = enc_i(12'd0, r1, 3'b000, 5'd0, 7'b1100111);
                end
                6: begin
                    c = {4'b1000, r1, r2, 2'b10};
                    w = enc_r(7'd0, r2, 5'd0, 3'b000, r1, 7'b0110011);
                end
                7: begin
                    c = {4'b1001, r1, r2, 2'b10};
                    w = enc_r(7'd0, r2, r1, 3'b000, r1, 7'b0110011);
                end
                8: begin
                    c = {3'b110, bo[8], bo[4:3], rp1, bo[7:6], bo[2:1], bo[5], 2'b01};
                    w = enc_b({{4{bo[8]}}, bo}, {2'b01, rp1}, 3'b000);
                end
                default: begin
                    c = {3'b111, bo[8], bo[4:3], rp1, bo[7:6], bo[2:1], bo[5], 2'b01};
                    w = enc_b({{4{bo[8]}}, bo}, {2'b01, rp1}, 3'b001);
                end
            endcase
            f = make_fetch({16'h0, c});
            push_and_get(f, d);
            check_fields(d, w, {16'h0, c}, f);
        end
    endtask

    task automatic test_bypass();
        logic [63:0] ex_data;
        logic [63:0] wb_data;
        decoded_t    d;
        fetch_t      f;
        ex_data = {next_rand(), next_rand()};
        wb_data = ~ex_data;
        @(negedge clk);
        bypass_exec      = '{rd: 5'd7, data: ex_data};
        bypass_writeback = '{rd: 5'd7, data: wb_data};
        f = make_fetch(enc_r(7'd0, 5'd0, 5'd7, 3'b000, 5'd1, 7'b0110011));
        push_and_get(f, d);
        check_val("rs1_data", d.rs1_data, ex_data);
        check_val("rs2_data", d.rs2_data, 64'd0);
        // Both forwards name x0 with nonzero data.
        @(negedge clk);
        bypass_exec      = '{rd: 5'd0, data: ex_data};
        bypass_writeback = '{rd: 5'd0, data: wb_data};
        f = make_fetch(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd1, 7'b0110011));
        push_and_get(f, d);
        check_val("rs1_data", d.rs1_data, 64'd0);
        check_val("rs2_data", d.rs2_data, 64'd0);
        @(negedge clk);
        bypass_exec      = '0;
        bypass_writeback = '0;
    endtask

    task automatic test_exceptions();
        logic [31:0] bad [3];
        decoded_t    d;
        fetch_t      f;
        // A legal word, then one that is illegal as well.
        for (int i = 0; i < 2; i++) begin
            f = make_fetch(i == 0 ? enc_i(12'h123, 5'd2, 3'b000, 5'd4, 7'b0010011)
                                  : 32'h0000_6105);
            f.exception  = 1'b1;
            f.trap_cause = 4'd5;
            push_and_get(f, d);
            check_val("exception", 64'(d.exception), 64'd1);
            check_val("trap_cause", 64'(d.trap_cause), 64'd5);
        end
        // Unsupported RVC, all zeros, unknown major opcode.
        bad = '{32'h0000_6105, 32'h0000_0000, 32'h0000_2087};
        for (int i = 0; i < 3; i++) begin
            f = make_fetch(bad[i]);
            push_and_get(f, d);
            check_val("exception", 64'(d.exception), 64'd1);
            check_val("trap_cause", 64'(d.trap_cause), 64'd2);
        end
    endtask

    task automatic test_backpressure_flush();
        fetch_t   stream [40];
        decoded_t held;
        logic     holding;
        logic     accept;
        int       in_idx;
        int       out_idx;
        int       n;
        for (int i = 0; i < 40; i++) begin
            stream[i] = make_fetch(enc_i(12'(i), 5'd1, 3'b000, 5'd2, 7'b0010011));
        end
        in_idx  = 0;
        out_idx = 0;
        holding = 1'b0;
        n       = 0;
        while (out_idx < 40) begin
            @(negedge clk);
            next_stalled = next_rand() % 3 == 0;
            prev_stalled = in_idx >= 40;
            if (in_idx < 40) fetch = stream[in_idx];
            #1;
            if (holding && decoded !== held) begin
                errors++;
                $display("FAIL %0t decoded got %h expected %h", $time, decoded, held);
            end
            holding = !stall_next && next_stalled;
            held    = decoded;
            accept  = !prev_stalled && !stall_prev;
            if (!stall_next && !next_stalled) begin
                check_val("original_instruction", 64'(decoded.original_instruction),
                          64'(stream[out_idx].instruction));
                check_val("addr", decoded.addr, stream[out_idx].addr);
                out_idx++;
            end
            if (accept) in_idx++;
            n++;
            if (n > 400) fail_timeout("the 40-item stream");
        end
        // Fill both stages, then flush.
        @(negedge clk);
        next_stalled = 1'b1;
        prev_stalled = 1'b0;
        fetch        = make_fetch(32'h0000_0013);
        n = 0;
        #1;
        while (!stall_prev) begin
            @(negedge clk);
            #1;
            n++;
            if (n > 20) fail_timeout("stall_prev high");
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush        = 1'b0;
        prev_stalled = 1'b1;
        next_stalled = 1'b0;
        repeat (4) begin
            check_val("stall_next", 64'(stall_next), 64'd1);
            @(negedge clk);
        end
    endtask

    initial begin
        rst_n            = 1'b0;
        flush            = 1'b0;
        fetch            = '0;
        prev_stalled     = 1'b1;
        next_stalled     = 1'b0;
        bypass_exec      = '0;
        bypass_writeback = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_val("stall_next", 64'(stall_next), 64'd1);
        check_val("stall_prev", 64'(stall_prev), 64'd0);
        test_register_read();
        test_immediates();
        test_compressed();
        test_bypass();
        test_exceptions();
        test_backpressure_flush();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
+incdir+design
design/decode_pkg.sv
design/decode_control.sv
design/decode_decompress.sv
design/decode_explode.sv
design/decode_regfile.sv
design/decode_stage.sv
sim/tb_decode_stage.sv

// ==== Makefile ====
SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)

obj_dir/Vtb_decode_stage: decode_stage.f $(SRCS)
	verilator --binary --timing -f decode_stage.f --top-module tb_decode_stage -Mdir obj_dir

.PHONY: run check clean

run: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage | tee sim.log

check: run
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
